/* dma_write_top.f */
verilog/dma_pkg.sv
verilog/dma_fifo.sv
verilog/burst_counter.sv
verilog/write_dest_fsm.sv
verilog/bandwidth_counter.sv
verilog/dma_write_top.sv
tb/axi_mem_model.sv
tb/dma_write_tb.sv

/* tb/axi_mem_model.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Answers only the last beat of a burst and keeps one b in flight
// Ready and response lines change on the falling edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module axi_mem_model (
   input  logic              clk,
   input  logic              reset_n,
   input  dma_pkg::t_resp    inject_resp,
   input  logic              aw_valid,
   output logic              aw_ready,
   input  dma_pkg::t_aw_chan aw,
   input  logic              w_valid,
   output logic              w_ready,
   input  dma_pkg::t_w_chan  w,
   output logic              b_valid,
   output dma_pkg::t_b_chan  b
);

   import dma_pkg::*;

   t_aw_chan   aw_log [$];
   t_w_chan    w_log [$];
   logic [2:0] b_delay;
   logic       aw_rdy = 1'b0;
   logic       w_rdy = 1'b0;
   logic       b_vld = 1'b0;
   t_b_chan    b_q = '{resp: OKAY};

   assign aw_ready = aw_rdy;
   assign w_ready  = w_rdy;
   assign b_valid  = b_vld;
   assign b        = b_q;

   // Log accepted traffic and start the response delay on a burst's last beat
   always @(posedge clk) begin
      if (!reset_n) begin
         b_delay <= '0;
      end else begin
         if (aw_valid && aw_ready) begin
            aw_log.push_back(aw);
         end
         if (w_valid && w_ready) begin
            w_log.push_back(w);
         end
         if (w_valid && w_ready && w.last) begin
            b_delay <= 3'($urandom_range(1, 4));
         end else if (b_delay != '0) begin
            b_delay <= b_delay - 1'b1;
         end
      end
   end

   always @(negedge clk) begin
      if (!reset_n) begin
         aw_rdy <= 1'b0;
         w_rdy  <= 1'b0;
         b_vld  <= 1'b0;
      end else begin
         // Ready about three cycles in four
         aw_rdy <= ($urandom_range(0, 3) != 0);
         w_rdy  <= ($urandom_range(0, 3) != 0);
         b_vld  <= (b_delay == 3'd1);
         b_q    <= '{resp: inject_resp};
      end
   end

endmodule

/* tb/dma_write_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected traffic is recorded as each descriptor and beat is pushed
// All descriptors are HOST_TO_DDR, so every burst is expected as INCR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dma_write_tb;

   import dma_pkg::*;

   localparam int TIMEOUT      = 2000;
   localparam int CHK_NONE     = 0;
   localparam int CHK_COUNTERS = 1;
   localparam int CHK_STOPPED  = 2;
   localparam int CHK_IDLE     = 3;

   logic              clk;
   logic              reset_n;
   logic              desc_push;
   t_dma_descriptor   desc_in;
   logic              desc_full;
   logic              data_push;
   logic [DATA_W-1:0] data_in;
   logic              data_full;
   t_dma_csr_control  csr_control;
   logic              aw_valid;
   logic              aw_ready;
   t_aw_chan          aw;
   logic              w_valid;
   logic              w_ready;
   t_w_chan           w;
   logic              b_valid;
   t_b_chan           b;
   t_dma_status       status;
   t_resp             inject_resp;

   t_aw_chan         exp_aw [32];
   t_w_chan          exp_w [128];
   t_aw_chan         exp_aw_head;
   t_w_chan          exp_w_head;
   int               aw_exp_cnt;
   int               w_exp_cnt;
   int               aw_idx;
   int               w_idx;
   int               check_kind;
   logic [CNT_W-1:0] exp_beats;
   logic [CNT_W-1:0] exp_min_clk;
   string            test_name;
   int               aw_errors;
   int               w_errors;
   int               status_errors;
   int               log_errors;
   int               timeouts;

   dma_write_top uut (
      .clk, .reset_n, .desc_push, .desc_in, .desc_full, .data_push, .data_in, .data_full,
      .csr_control, .aw_valid, .aw_ready, .aw, .w_valid, .w_ready, .w, .b_valid, .b, .status
   );

   axi_mem_model mem (
      .clk, .reset_n, .inject_resp, .aw_valid, .aw_ready, .aw, .w_valid, .w_ready, .w,
      .b_valid, .b
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   assign exp_aw_head = exp_aw[aw_idx];
   assign exp_w_head  = exp_w[w_idx];

   always @(posedge clk) begin
      if (!reset_n) begin
         aw_idx <= 0;
         w_idx  <= 0;
      end else begin
         if (aw_valid && aw_ready) aw_idx <= aw_idx + 1;
         if (w_valid && w_ready) w_idx <= w_idx + 1;
      end
   end

   a_aw_match: assert property (@(posedge clk) disable iff (!reset_n)
      aw_valid && aw_ready |-> aw_idx < aw_exp_cnt && aw == exp_aw_head)
      else begin
         aw_errors++;
         $display("[ERROR] %s aw expected %h actual %h", test_name,
                  $sampled(exp_aw_head), $sampled(aw));
      end
   a_w_match: assert property (@(posedge clk) disable iff (!reset_n)
      w_valid && w_ready |-> w_idx < w_exp_cnt && w == exp_w_head)
      else begin
         w_errors++;
         $display("[ERROR] %s w expected %h actual %h", test_name,
                  $sampled(exp_w_head), $sampled(w));
      end
   a_valid_cnt: assert property (@(posedge clk) disable iff (!reset_n)
      check_kind == CHK_COUNTERS |-> status.valid_cnt == exp_beats)
      else begin
         status_errors++;
         $display("[ERROR] %s valid_cnt expected %0d actual %0d", test_name,
                  $sampled(exp_beats), $sampled(status.valid_cnt));
      end
   a_clk_cnt: assert property (@(posedge clk) disable iff (!reset_n)
      check_kind == CHK_COUNTERS |-> status.clk_cnt >= exp_min_clk)
      else begin
         status_errors++;
         $display("[ERROR] %s clk_cnt expected at least %0d actual %0d", test_name,
                  $sampled(exp_min_clk), $sampled(status.clk_cnt));
      end
   a_stopped: assert property (@(posedge clk) disable iff (!reset_n)
      check_kind == CHK_STOPPED |-> status.stopped_on_error && status.wr_rsp_err && status.busy)
      else begin
         status_errors++;
         $display("%s: engine is not held stopped with its error flags set", test_name);
      end
   a_idle: assert property (@(posedge clk) disable iff (!reset_n)
      check_kind == CHK_IDLE |-> !status.busy && status.wr_state == IDLE &&
         !status.stopped_on_error && !status.wr_rsp_err && !aw_valid && !w_valid &&
         !desc_full && !data_full)
      else begin
         status_errors++;
         $display("%s: engine is not idle with clear flags, channels and FIFOs", test_name);
      end

   task automatic push_descriptor(input logic [ADDR_W-1:0] addr, input int length);
      int bursts;
      int k;
      bursts = (length + 15) / 16;
      // Bursts step 128 bytes and 8-byte beats give size 3
      for (k = 0; k < bursts; k++) begin
         exp_aw[aw_exp_cnt] = '{addr: addr + 32'(k * 128),
                                len: (k == bursts - 1) ? 4'((length - 1) % 16) : 4'd15,
                                burst: BURST_INCR, size: 3'd3};
         aw_exp_cnt++;
      end
      desc_push = 1'b1;
      desc_in   = '{dest_addr: addr, length: 16'(length), mode: HOST_TO_DDR, go: 1'b1};
      @(negedge clk);
      desc_push = 1'b0;
   endtask

   task automatic push_beats(input int length);
      logic [DATA_W-1:0] word;
      int                cycles;
      int                i;
      for (i = 0; i < length; i++) begin
         word = {$urandom, $urandom};
         exp_w[w_exp_cnt] = '{data: word, last: (i % 16 == 15) || (i == length - 1)};
         w_exp_cnt++;
         @(negedge clk);
         cycles = 0;
         while (data_full && cycles < TIMEOUT) begin
            data_push = 1'b0;
            @(negedge clk);
            cycles++;
         end
         if (data_full) begin
            timeouts++;
            $display("%s: timeout, data FIFO never drained", test_name);
         end
         data_push = 1'b1;
         data_in   = word;
      end
      @(negedge clk);
      data_push = 1'b0;
   endtask

   // Done means every expected beat has left and the engine went idle
   task automatic wait_transfer_done();
      int cycles;
      cycles = 0;
      while (!(w_idx == w_exp_cnt && !status.busy) && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= TIMEOUT) begin
         timeouts++;
         $display("%s: timeout, transfer did not complete", test_name);
      end
   endtask

   task automatic wait_error_stop();
      int cycles;
      cycles = 0;
      while (!status.stopped_on_error && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= TIMEOUT) begin
         timeouts++;
         $display("%s: timeout, engine did not stop on the error response", test_name);
      end
   endtask

   task automatic run_check(input int kind);
      @(negedge clk);
      check_kind = kind;
      @(negedge clk);
      check_kind = CHK_NONE;
   endtask

   task automatic check_log_counts();
      assert (mem.aw_log.size() == aw_exp_cnt) else begin
         log_errors++;
         $display("[ERROR] %s aw count expected %0d actual %0d", test_name, aw_exp_cnt,
                  mem.aw_log.size());
      end
      assert (mem.w_log.size() == w_exp_cnt) else begin
         log_errors++;
         $display("[ERROR] %s w count expected %0d actual %0d", test_name, w_exp_cnt,
                  mem.w_log.size());
      end
   endtask

   initial begin
      void'($urandom(32'h932a));
      reset_n     = 1'b0;
      desc_push   = 1'b0;
      desc_in     = '0;
      data_push   = 1'b0;
      data_in     = '0;
      csr_control = '0;
      inject_resp = OKAY;
      check_kind  = CHK_NONE;
      test_name   = "reset";
      repeat (16) @(negedge clk);
      reset_n = 1'b1;
      run_check(CHK_IDLE);

      test_name = "burst_split";
      push_descriptor(32'h1000, 40);
      push_beats(40);
      wait_transfer_done();
      exp_beats   = 40;
      exp_min_clk = 43;
      run_check(CHK_COUNTERS);

      test_name = "single_beat";
      push_descriptor(32'h2000, 1);
      push_beats(1);
      wait_transfer_done();
      exp_beats   = 1;
      exp_min_clk = 2;
      run_check(CHK_COUNTERS);

      test_name   = "error_stop";
      inject_resp = SLVERR;
      push_descriptor(32'h3000, 5);
      push_beats(5);
      wait_error_stop();
      inject_resp = OKAY;
      run_check(CHK_STOPPED);
      repeat (8) @(negedge clk);
      run_check(CHK_STOPPED);
      csr_control.reset_dispatcher = 1'b1;
      @(negedge clk);
      csr_control.reset_dispatcher = 1'b0;
      wait_transfer_done();
      run_check(CHK_IDLE);

      test_name = "error_recovery";
      push_descriptor(32'h3400, 18);
      push_beats(18);
      wait_transfer_done();

      test_name = "queued";
      push_descriptor(32'h4000, 20);
      push_descriptor(32'h5000, 3);
      push_beats(20);
      push_beats(3);
      wait_transfer_done();
      run_check(CHK_IDLE);

      test_name = "log_check";
      check_log_counts();
      $display("Errors: aw %0d, w %0d, status %0d, log %0d, timeouts %0d",
               aw_errors, w_errors, status_errors, log_errors, timeouts);
      if (aw_errors + w_errors + status_errors + log_errors + timeouts == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* verilog/bandwidth_counter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counts wrap silently at 2**32
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bandwidth_counter (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      clear,
   input  logic                      run,
   input  logic                      beat,
   output logic [dma_pkg::CNT_W-1:0] clk_cnt,
   output logic [dma_pkg::CNT_W-1:0] valid_cnt
);

   import dma_pkg::*;

   // Values hold after a transfer so software can read them back
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         clk_cnt   <= '0;
         valid_cnt <= '0;
      end else if (clear) begin
         clk_cnt   <= '0;
         valid_cnt <= '0;
      end else if (run) begin
         clk_cnt   <= clk_cnt + 1'b1;
         valid_cnt <= valid_cnt + CNT_W'(beat);
      end
   end

endmodule

/* verilog/burst_counter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// desc must stay stable from load until the descriptor is popped
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module burst_counter (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          load,
   input  dma_pkg::t_dma_descriptor      desc,
   input  logic                          beat,
   output logic [dma_pkg::ADDR_W-1:0]    burst_addr,
   output logic [dma_pkg::AXI_LEN_W-1:0] burst_len,
   output logic                          beat_last,
   output logic                          more_bursts
);

   import dma_pkg::*;

   logic [LENGTH_W-1:0] len_m1;
   logic [LENGTH_W-1:0] beat_cnt;
   logic [BURSTS_W-1:0] bursts_done;
   logic [BURSTS_W-1:0] num_bursts;
   logic                final_burst;

   assign len_m1      = desc.length - 1'b1;
   assign final_burst = (bursts_done == num_bursts - 1'b1);

   // Bursts start on 128-byte steps from the descriptor address
   assign burst_addr  = desc.dest_addr + ADDR_W'(bursts_done) * ADDR_W'(BURST_BYTES);
   assign burst_len   = final_burst ? len_m1[AXI_LEN_W-1:0] : '1;

   // Bursts are aligned to 16-beat boundaries within the descriptor
   assign beat_last   = (beat_cnt[AXI_LEN_W-1:0] == '1) || (beat_cnt == len_m1);
   assign more_bursts = (bursts_done < num_bursts);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         beat_cnt    <= '0;
         bursts_done <= '0;
         num_bursts  <= '0;
      end else if (load) begin
         beat_cnt    <= '0;
         bursts_done <= '0;
         num_bursts  <= BURSTS_W'(len_m1 >> AXI_LEN_W) + 1'b1;
      end else if (beat) begin
         beat_cnt <= beat_cnt + 1'b1;
         if (beat_last) begin
            bursts_done <= bursts_done + 1'b1;
         end
      end
   end

   // FSM must stop taking beats once the descriptor is exhausted
   a_no_extra_beat: assert property (@(posedge clk) disable iff (!reset_n)
      beat |-> (beat_cnt < desc.length))
      else $error("burst_counter: beat after final beat of descriptor");

endmodule

/* verilog/dma_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Show-ahead FIFO that drops a push while full
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dma_fifo #(
   parameter type entry_t = logic [7:0],
   parameter int  DEPTH   = 4
) (
   input  logic   clk,
   input  logic   reset_n,
   input  logic   push,
   input  entry_t wr_data,
   output logic   full,
   input  logic   pop,
   output entry_t rd_data,
   output logic   not_empty
);

   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int FILL_W = $clog2(DEPTH + 1);

   entry_t            mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [FILL_W-1:0] fill;
   logic              do_push;
   logic              do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign do_push   = push && !full;
   assign do_pop    = pop && not_empty;
   assign full      = (fill == FILL_W'(DEPTH));
   assign not_empty = (fill != '0);
   // Head is presented without a read cycle
   assign rd_data   = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         fill <= fill + FILL_W'(do_push) - FILL_W'(do_pop);
      end
   end

   a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n) push |-> !full)
      else $error("dma_fifo: push while full, entry dropped");
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n) pop |-> not_empty)
      else $error("dma_fifo: pop while empty");

endmodule

/* verilog/dma_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes assume 64-bit beats and bursts of at most 16 beats
// BURST_WRAP is encoded but the engine never issues it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dma_pkg;

   localparam int DATA_W       = 64;
   localparam int DATA_BYTES   = DATA_W / 8;
   localparam int ADDR_W       = 32;
   localparam int LENGTH_W     = 16;
   localparam int AXI_LEN_W    = 4;
   localparam int AXI_SIZE_W   = 3;
   localparam int BURST_BYTES  = DATA_BYTES * (2 ** AXI_LEN_W);
   localparam int BURSTS_W     = LENGTH_W - AXI_LEN_W + 1;
   localparam int ADDR_GAP     = 3;
   localparam int GAP_W        = $clog2(ADDR_GAP);
   localparam int CNT_W        = 32;
   localparam int DESC_DEPTH   = 4;
   localparam int DATA_DEPTH   = 32;
   localparam bit ENABLE_ERROR = 1'b1;

   // One-hot bit positions of the write FSM
   localparam int S_IDLE            = 0;
   localparam int S_ADDR_PROP_DELAY = 1;
   localparam int S_ADDR_SETUP      = 2;
   localparam int S_FIFO_EMPTY      = 3;
   localparam int S_RD_FIFO_WR_DEST = 4;
   localparam int S_WAIT_FOR_WR_RSP = 5;
   localparam int S_ERROR           = 6;
   localparam int NUM_WR_STATES     = 7;

   typedef enum logic [1:0] {STAND_BY, HOST_TO_DDR, DDR_TO_HOST, DDR_TO_DDR} t_dma_mode;
   typedef enum logic [1:0] {BURST_FIXED, BURST_INCR, BURST_WRAP} t_burst;
   typedef enum logic [1:0] {OKAY, EXOKAY, SLVERR, DECERR} t_resp;

   typedef enum logic [NUM_WR_STATES-1:0] {
      IDLE            = NUM_WR_STATES'(1 << S_IDLE),
      ADDR_PROP_DELAY = NUM_WR_STATES'(1 << S_ADDR_PROP_DELAY),
      ADDR_SETUP      = NUM_WR_STATES'(1 << S_ADDR_SETUP),
      FIFO_EMPTY      = NUM_WR_STATES'(1 << S_FIFO_EMPTY),
      RD_FIFO_WR_DEST = NUM_WR_STATES'(1 << S_RD_FIFO_WR_DEST),
      WAIT_FOR_WR_RSP = NUM_WR_STATES'(1 << S_WAIT_FOR_WR_RSP),
      ERROR           = NUM_WR_STATES'(1 << S_ERROR)
   } t_wr_state;

   // Length is in beats and never zero
   typedef struct packed {
      logic [ADDR_W-1:0]   dest_addr;
      logic [LENGTH_W-1:0] length;
      t_dma_mode           mode;
      logic                go;
   } t_dma_descriptor;

   typedef struct packed {
      logic [ADDR_W-1:0]     addr;
      logic [AXI_LEN_W-1:0]  len;
      t_burst                burst;
      logic [AXI_SIZE_W-1:0] size;
   } t_aw_chan;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } t_w_chan;

   typedef struct packed {
      t_resp resp;
   } t_b_chan;

   typedef struct packed {
      logic             busy;
      logic             stopped_on_error;
      logic             wr_rsp_err;
      t_wr_state        wr_state;
      logic [CNT_W-1:0] clk_cnt;
      logic [CNT_W-1:0] valid_cnt;
   } t_dma_status;

   typedef struct packed {
      logic reset_dispatcher;
   } t_dma_csr_control;

endpackage

/* verilog/dma_write_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host pushes to a full FIFO are lost
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dma_write_top (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       desc_push,
   input  dma_pkg::t_dma_descriptor   desc_in,
   output logic                       desc_full,
   input  logic                       data_push,
   input  logic [dma_pkg::DATA_W-1:0] data_in,
   output logic                       data_full,
   input  dma_pkg::t_dma_csr_control  csr_control,
   output logic                       aw_valid,
   input  logic                       aw_ready,
   output dma_pkg::t_aw_chan          aw,
   output logic                       w_valid,
   input  logic                       w_ready,
   output dma_pkg::t_w_chan           w,
   input  logic                       b_valid,
   input  dma_pkg::t_b_chan           b,
   output dma_pkg::t_dma_status       status
);

   import dma_pkg::*;

   t_dma_descriptor      desc;
   logic                 desc_valid;
   logic                 desc_pop;
   logic [DATA_W-1:0]    data;
   logic                 data_valid;
   logic                 data_rd;
   logic [ADDR_W-1:0]    burst_addr;
   logic [AXI_LEN_W-1:0] burst_len;
   logic                 beat_last;
   logic                 more_bursts;
   logic                 load;
   logic                 beat;
   t_wr_state            wr_state;
   logic                 busy;
   logic                 stopped_on_error;
   logic                 wr_rsp_err;
   logic [CNT_W-1:0]     clk_cnt;
   logic [CNT_W-1:0]     valid_cnt;

   dma_fifo #(.entry_t(t_dma_descriptor), .DEPTH(DESC_DEPTH)) desc_fifo (
      .clk, .reset_n, .push(desc_push), .wr_data(desc_in), .full(desc_full),
      .pop(desc_pop), .rd_data(desc), .not_empty(desc_valid)
   );

   dma_fifo #(.entry_t(logic [DATA_W-1:0]), .DEPTH(DATA_DEPTH)) data_fifo (
      .clk, .reset_n, .push(data_push), .wr_data(data_in), .full(data_full),
      .pop(data_rd), .rd_data(data), .not_empty(data_valid)
   );

   write_dest_fsm fsm (
      .clk, .reset_n, .desc_valid, .desc, .desc_pop, .data_valid, .data, .data_rd,
      .csr_control, .aw_valid, .aw_ready, .aw, .w_valid, .w_ready, .w, .b_valid, .b,
      .state(wr_state), .busy, .stopped_on_error, .wr_rsp_err,
      .burst_addr, .burst_len, .beat_last, .more_bursts, .load, .beat
   );

   burst_counter bursts (
      .clk, .reset_n, .load, .desc, .beat, .burst_addr, .burst_len, .beat_last, .more_bursts
   );

   // Clear on transfer start and count only beats accepted by memory
   bandwidth_counter bw (
      .clk, .reset_n, .clear(load), .run(busy), .beat(w_valid && w_ready), .clk_cnt, .valid_cnt
   );

   assign status = '{
      busy:             busy,
      stopped_on_error: stopped_on_error,
      wr_rsp_err:       wr_rsp_err,
      wr_state:         wr_state,
      clk_cnt:          clk_cnt,
      valid_cnt:        valid_cnt
   };

endmodule

/* verilog/write_dest_fsm.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One descriptor in flight and only the final b is checked
// Strobes are implied full and b is always accepted
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module write_dest_fsm (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          desc_valid,
   input  dma_pkg::t_dma_descriptor      desc,
   output logic                          desc_pop,
   input  logic                          data_valid,
   input  logic [dma_pkg::DATA_W-1:0]    data,
   output logic                          data_rd,
   input  dma_pkg::t_dma_csr_control     csr_control,
   output logic                          aw_valid,
   input  logic                          aw_ready,
   output dma_pkg::t_aw_chan             aw,
   output logic                          w_valid,
   input  logic                          w_ready,
   output dma_pkg::t_w_chan              w,
   input  logic                          b_valid,
   input  dma_pkg::t_b_chan              b,
   output dma_pkg::t_wr_state            state,
   output logic                          busy,
   output logic                          stopped_on_error,
   output logic                          wr_rsp_err,
   input  logic [dma_pkg::ADDR_W-1:0]    burst_addr,
   input  logic [dma_pkg::AXI_LEN_W-1:0] burst_len,
   input  logic                          beat_last,
   input  logic                          more_bursts,
   output logic                          load,
   output logic                          beat
);

   import dma_pkg::*;

   t_wr_state        next;
   logic [GAP_W-1:0] gap_cnt;
   logic             aw_issue;
   logic             rsp_err;
   logic             rsp_ok;
   logic             w_done;
   logic             w_free;

   function automatic t_burst get_burst(input t_dma_mode mode);
      case (mode)
         HOST_TO_DDR: return BURST_INCR;
         // Host-bound writes also go out as INCR
         DDR_TO_HOST: return BURST_INCR;
         DDR_TO_DDR:  return BURST_INCR;
         default:     return BURST_FIXED;
      endcase
   endfunction

   assign load     = state[S_IDLE] && desc_valid && desc.go && aw_ready;
   assign aw_issue = state[S_ADDR_SETUP] && !aw_valid;

   // W holding register frees up when its beat leaves, unless that beat ends the burst
   assign w_done  = w_valid && w_ready && w.last;
   assign w_free  = !w_valid || (w_ready && !w.last);
   assign data_rd = state[S_RD_FIFO_WR_DEST] && data_valid && w_free;
   assign beat    = data_rd;

   assign rsp_err  = (b.resp == SLVERR) || (b.resp == DECERR);
   assign rsp_ok   = b_valid && !(ENABLE_ERROR && rsp_err);
   assign desc_pop = (state[S_WAIT_FOR_WR_RSP] && rsp_ok) ||
                     (state[S_ERROR] && csr_control.reset_dispatcher);

   assign busy             = !state[S_IDLE];
   assign stopped_on_error = state[S_ERROR];
   assign wr_rsp_err       = state[S_ERROR];

   always_comb begin
      next = state;
      unique case (1'b1)
         state[S_IDLE]: begin
            if (load) next = ADDR_SETUP;
         end
         state[S_ADDR_PROP_DELAY]: begin
            if (gap_cnt == GAP_W'(ADDR_GAP - 1)) next = ADDR_SETUP;
         end
         state[S_ADDR_SETUP]: begin
            if (aw_valid && aw_ready) next = FIFO_EMPTY;
         end
         state[S_FIFO_EMPTY], state[S_RD_FIFO_WR_DEST]: begin
            if (w_done) begin
               if (more_bursts) next = ADDR_PROP_DELAY;
               else next = WAIT_FOR_WR_RSP;
            end else if (data_valid) begin
               next = RD_FIFO_WR_DEST;
            end else begin
               next = FIFO_EMPTY;
            end
         end
         state[S_WAIT_FOR_WR_RSP]: begin
            if (rsp_ok) next = IDLE;
            else if (b_valid) next = ERROR;
         end
         state[S_ERROR]: begin
            if (csr_control.reset_dispatcher) next = IDLE;
         end
         default: next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= IDLE;
         gap_cnt  <= '0;
         aw_valid <= 1'b0;
         w_valid  <= 1'b0;
      end else begin
         state   <= next;
         gap_cnt <= state[S_ADDR_PROP_DELAY] ? gap_cnt + 1'b1 : '0;
         if (aw_issue) begin
            aw_valid <= 1'b1;
         end else if (aw_valid && aw_ready) begin
            aw_valid <= 1'b0;
         end
         if (data_rd) begin
            w_valid <= 1'b1;
         end else if (w_valid && w_ready) begin
            w_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_issue) begin
         aw.addr  <= burst_addr;
         aw.len   <= burst_len;
         aw.burst <= get_burst(desc.mode);
         aw.size  <= AXI_SIZE_W'($clog2(DATA_BYTES));
      end
      if (data_rd) begin
         w.data <= data;
         w.last <= beat_last;
      end
   end

   a_aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw))
      else $error("write_dest_fsm: aw changed before acceptance");
   a_w_hold: assert property (@(posedge clk) disable iff (!reset_n)
      w_valid && !w_ready |=> w_valid && $stable(w))
      else $error("write_dest_fsm: w dropped or changed before transfer");

endmodule
